// ==== logic/bpu_conf_pkg.sv ====
`default_nettype none

package bpu_conf_pkg;

  localparam int VADDR_W = 32;

  // history length equals the counter table index width
  localparam int GSHARE_BHT_W = 8;

  localparam int BTB_ENTRY_SIZE = 16;
  localparam int BTB_IDX_W = $clog2(BTB_ENTRY_SIZE);
  // pc bits [1:0] never take part in index or tag
  localparam int BTB_TAG_W = VADDR_W - BTB_IDX_W - 2;

  localparam int RAS_ENTRY_SIZE = 8;
  localparam int RAS_IDX_W = $clog2(RAS_ENTRY_SIZE);

endpackage

`default_nettype wire

// ==== logic/bpu_types_pkg.sv ====
`default_nettype none

package bpu_types_pkg;

  import bpu_conf_pkg::*;

  typedef logic [VADDR_W-1:0]      vaddr_t;
  typedef logic [GSHARE_BHT_W-1:0] bht_idx_t;
  typedef logic [RAS_IDX_W-1:0]    ras_idx_t;
  typedef logic [1:0]              bim_t;

  // one resolved branch as returned by the branch unit
  typedef struct packed {
    logic     taken;
    logic     mispredict;
    logic     is_cond;
    logic     is_call;
    logic     is_ret;
    logic     is_rvc;
    ras_idx_t ras_index;
    bim_t     bim_value;
    vaddr_t   pc_vaddr;
    vaddr_t   target_vaddr;
    vaddr_t   ras_prev_vaddr;
    bht_idx_t gshare_index;
    bht_idx_t gshare_bhr;
  } br_upd_t;

  typedef struct packed {
    logic     taken;
    logic     btb_hit;
    vaddr_t   target_vaddr;
    bht_idx_t gshare_index;
    bht_idx_t gshare_bhr;
    bim_t     bim_value;
    ras_idx_t ras_index;
    vaddr_t   ras_prev_vaddr;
  } pred_resp_t;

endpackage

`default_nettype wire

// ==== logic/bpu_stage.sv ====
`default_nettype none

module bpu_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // payload only moves with a valid beat
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_data <= in_data;
    end
  end

  // a stray X on the valid would poison every table write downstream
  a_valid_known : assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(out_valid)
  );

endmodule

`default_nettype wire

// ==== logic/gshare_bht.sv ====
`default_nettype none

module gshare_bht
  import bpu_conf_pkg::*, bpu_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     lookup_valid,
  input  vaddr_t   lookup_pc,
  input  logic     upd_valid,
  input  logic     upd_is_cond,
  input  logic     upd_taken,
  input  bht_idx_t upd_gshare_index,
  input  bht_idx_t upd_gshare_bhr,
  input  bim_t     upd_bim_value,
  output bht_idx_t rd_index,
  output bht_idx_t rd_bhr,
  output bim_t     rd_bim_value
);

  bim_t     bht_q [2**GSHARE_BHT_W];
  bht_idx_t bhr_q;
  bht_idx_t lookup_index;
  logic     upd_cond;
  bim_t     upd_bim_next;

  assign lookup_index = lookup_pc[GSHARE_BHT_W+1:2] ^ bhr_q;
  assign upd_cond = upd_valid & upd_is_cond;

  // saturating step from the counter value seen at lookup time
  always_comb begin
    if (upd_taken) begin
      upd_bim_next = (upd_bim_value == 2'd3) ? 2'd3 : upd_bim_value + 2'd1;
    end else begin
      upd_bim_next = (upd_bim_value == 2'd0) ? 2'd0 : upd_bim_value - 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**GSHARE_BHT_W; i++) begin
        bht_q[i] <= 2'd1;
      end
      bhr_q <= '0;
    end else if (upd_cond) begin
      bht_q[upd_gshare_index] <= upd_bim_next;
      // history is rebuilt from the record, hit or mispredict
      bhr_q <= {upd_gshare_bhr[GSHARE_BHT_W-2:0], upd_taken};
    end
  end

  // registered read, sees the table as it was before this edge's write
  always_ff @(posedge clk) begin
    if (lookup_valid) begin
      rd_index <= lookup_index;
      rd_bhr <= bhr_q;
      rd_bim_value <= bht_q[lookup_index];
    end
  end

  a_no_write_uncond : assert property (
    @(posedge clk) disable iff (rst)
    (upd_valid && !upd_is_cond) |=>
      (bht_q[$past(upd_gshare_index)] == $past(bht_q[upd_gshare_index])) &&
      (bhr_q == $past(bhr_q))
  );

endmodule

`default_nettype wire

// ==== logic/btb.sv ====
`default_nettype none

module btb
  import bpu_conf_pkg::*, bpu_types_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   lookup_valid,
  input  vaddr_t lookup_pc,
  input  logic   upd_valid,
  input  logic   upd_taken,
  input  vaddr_t upd_pc,
  input  vaddr_t upd_target,
  output logic   rd_hit,
  output vaddr_t rd_target
);

  logic                 valid_q  [BTB_ENTRY_SIZE];
  logic [BTB_TAG_W-1:0] tag_q    [BTB_ENTRY_SIZE];
  vaddr_t               target_q [BTB_ENTRY_SIZE];

  logic [BTB_IDX_W-1:0] lookup_idx;
  logic [BTB_TAG_W-1:0] lookup_tag;
  logic [BTB_IDX_W-1:0] upd_idx;
  logic [BTB_TAG_W-1:0] upd_tag;
  logic                 upd_we;

  assign lookup_idx = lookup_pc[BTB_IDX_W+1:2];
  assign lookup_tag = lookup_pc[VADDR_W-1:BTB_IDX_W+2];
  assign upd_idx = upd_pc[BTB_IDX_W+1:2];
  assign upd_tag = upd_pc[VADDR_W-1:BTB_IDX_W+2];

  // only taken branches allocate
  assign upd_we = upd_valid & upd_taken;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < BTB_ENTRY_SIZE; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (upd_we) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (upd_we) begin
      tag_q[upd_idx] <= upd_tag;
      target_q[upd_idx] <= upd_target;
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_valid) begin
      rd_hit <= valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
      rd_target <= target_q[lookup_idx];
    end
  end

endmodule

`default_nettype wire

// ==== logic/ras.sv ====
`default_nettype none

module ras
  import bpu_conf_pkg::*, bpu_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  logic     pop,
  input  vaddr_t   push_addr,
  input  logic     repair,
  input  ras_idx_t repair_index,
  input  vaddr_t   repair_addr,
  input  logic     repair_push,
  input  logic     repair_pop,
  input  vaddr_t   repair_push_addr,
  output ras_idx_t top_index,
  output vaddr_t   top_addr
);

  // ptr_q names the top entry, so a push writes one slot above it
  vaddr_t   stack_q [RAS_ENTRY_SIZE];
  ras_idx_t ptr_q;
  ras_idx_t push_slot;
  ras_idx_t repair_up;
  ras_idx_t repair_down;

  assign push_slot = ptr_q + 1'b1;
  assign repair_up = repair_index + 1'b1;
  assign repair_down = repair_index - 1'b1;

  assign top_index = ptr_q;
  assign top_addr = stack_q[ptr_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q <= '0;
    end else if (repair) begin
      if (repair_push) begin
        ptr_q <= repair_up;
      end else if (repair_pop) begin
        ptr_q <= repair_down;
      end else begin
        ptr_q <= repair_index;
      end
    end else if (push) begin
      ptr_q <= push_slot;
    end else if (pop) begin
      ptr_q <= ptr_q - 1'b1;
    end
  end

  // wrong-path push/pop in the same cycle as a repair is dropped
  always_ff @(posedge clk) begin
    if (repair) begin
      stack_q[repair_index] <= repair_addr;
      if (repair_push) begin
        stack_q[repair_up] <= repair_push_addr;
      end
    end else if (push) begin
      stack_q[push_slot] <= push_addr;
    end
  end

  a_lookup_excl : assert property (
    @(posedge clk) disable iff (rst)
    !(push && pop)
  );

  a_repair_excl : assert property (
    @(posedge clk) disable iff (rst)
    repair |-> !(repair_push && repair_pop)
  );

endmodule

`default_nettype wire

// ==== logic/bpu_top.sv ====
`default_nettype none

module bpu_top
  import bpu_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  input  logic     lookup_valid,
  input  vaddr_t   lookup_pc,
  input  logic     lookup_is_cond,
  input  logic     lookup_is_call,
  input  logic     lookup_is_ret,
  input  logic     lookup_is_rvc,

  output logic     pred_valid,
  output logic     pred_taken,
  output logic     pred_btb_hit,
  output vaddr_t   pred_target,
  output bht_idx_t pred_gshare_index,
  output bht_idx_t pred_gshare_bhr,
  output bim_t     pred_bim_value,
  output ras_idx_t pred_ras_index,
  output vaddr_t   pred_ras_prev_vaddr,

  input  logic     update,
  input  logic     dead,
  input  logic     upd_taken,
  input  logic     upd_mispredict,
  input  logic     upd_is_cond,
  input  logic     upd_is_call,
  input  logic     upd_is_ret,
  input  logic     upd_is_rvc,
  input  ras_idx_t upd_ras_index,
  input  bim_t     upd_bim_value,
  input  vaddr_t   upd_pc_vaddr,
  input  vaddr_t   upd_target_vaddr,
  input  vaddr_t   upd_ras_prev_vaddr,
  input  bht_idx_t upd_gshare_index,
  input  bht_idx_t upd_gshare_bhr
);

  br_upd_t    upd_in;
  br_upd_t    upd_q;
  logic       upd_q_valid;

  bht_idx_t   bht_index;
  bht_idx_t   bht_bhr;
  bim_t       bht_bim;
  logic       btb_hit;
  vaddr_t     btb_target;
  ras_idx_t   ras_top_index;
  vaddr_t     ras_top_addr;

  logic       s1_valid;
  logic       s1_is_cond;
  logic       s1_is_ret;
  ras_idx_t   s1_ras_index;
  vaddr_t     s1_ras_top;
  pred_resp_t resp;
  pred_resp_t resp_q;

  function automatic vaddr_t ret_addr(input vaddr_t pc, input logic rvc);
    return pc + (rvc ? vaddr_t'(2) : vaddr_t'(4));
  endfunction

  assign upd_in = '{
    taken:          upd_taken,
    mispredict:     upd_mispredict,
    is_cond:        upd_is_cond,
    is_call:        upd_is_call,
    is_ret:         upd_is_ret,
    is_rvc:         upd_is_rvc,
    ras_index:      upd_ras_index,
    bim_value:      upd_bim_value,
    pc_vaddr:       upd_pc_vaddr,
    target_vaddr:   upd_target_vaddr,
    ras_prev_vaddr: upd_ras_prev_vaddr,
    gshare_index:   upd_gshare_index,
    gshare_bhr:     upd_gshare_bhr
  };

  // killed branches never reach the tables
  bpu_stage #(.payload_t(br_upd_t)) upd_stage_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (update & ~dead),
    .in_data   (upd_in),
    .out_valid (upd_q_valid),
    .out_data  (upd_q)
  );

  gshare_bht gshare_bht_i (
    .clk              (clk),
    .rst              (rst),
    .lookup_valid     (lookup_valid),
    .lookup_pc        (lookup_pc),
    .upd_valid        (upd_q_valid),
    .upd_is_cond      (upd_q.is_cond),
    .upd_taken        (upd_q.taken),
    .upd_gshare_index (upd_q.gshare_index),
    .upd_gshare_bhr   (upd_q.gshare_bhr),
    .upd_bim_value    (upd_q.bim_value),
    .rd_index         (bht_index),
    .rd_bhr           (bht_bhr),
    .rd_bim_value     (bht_bim)
  );

  btb btb_i (
    .clk          (clk),
    .rst          (rst),
    .lookup_valid (lookup_valid),
    .lookup_pc    (lookup_pc),
    .upd_valid    (upd_q_valid),
    .upd_taken    (upd_q.taken),
    .upd_pc       (upd_q.pc_vaddr),
    .upd_target   (upd_q.target_vaddr),
    .rd_hit       (btb_hit),
    .rd_target    (btb_target)
  );

  ras ras_i (
    .clk              (clk),
    .rst              (rst),
    .push             (lookup_valid & lookup_is_call),
    .pop              (lookup_valid & lookup_is_ret),
    .push_addr        (ret_addr(lookup_pc, lookup_is_rvc)),
    .repair           (upd_q_valid & upd_q.mispredict),
    .repair_index     (upd_q.ras_index),
    .repair_addr      (upd_q.ras_prev_vaddr),
    .repair_push      (upd_q.is_call),
    .repair_pop       (upd_q.is_ret),
    .repair_push_addr (ret_addr(upd_q.pc_vaddr, upd_q.is_rvc)),
    .top_index        (ras_top_index),
    .top_addr         (ras_top_addr)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= lookup_valid;
    end
  end

  // hints and ras state held to line up with the table read registers
  always_ff @(posedge clk) begin
    if (lookup_valid) begin
      s1_is_cond <= lookup_is_cond;
      s1_is_ret <= lookup_is_ret;
      s1_ras_index <= ras_top_index;
      s1_ras_top <= ras_top_addr;
    end
  end

  // a ret goes to the ras top even when the btb has no entry
  assign resp.taken = s1_is_ret | (btb_hit & (~s1_is_cond | bht_bim[1]));
  assign resp.btb_hit = btb_hit;
  assign resp.target_vaddr = s1_is_ret ? s1_ras_top : btb_target;
  assign resp.gshare_index = bht_index;
  assign resp.gshare_bhr = bht_bhr;
  assign resp.bim_value = bht_bim;
  assign resp.ras_index = s1_ras_index;
  assign resp.ras_prev_vaddr = s1_ras_top;

  bpu_stage #(.payload_t(pred_resp_t)) resp_stage_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (s1_valid),
    .in_data   (resp),
    .out_valid (pred_valid),
    .out_data  (resp_q)
  );

  assign pred_taken = resp_q.taken;
  assign pred_btb_hit = resp_q.btb_hit;
  assign pred_target = resp_q.target_vaddr;
  assign pred_gshare_index = resp_q.gshare_index;
  assign pred_gshare_bhr = resp_q.gshare_bhr;
  assign pred_bim_value = resp_q.bim_value;
  assign pred_ras_index = resp_q.ras_index;
  assign pred_ras_prev_vaddr = resp_q.ras_prev_vaddr;

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held for the first 8 rising edges
  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== verification/bpu_tb.sv ====
`default_nettype none

module bpu_tb
  import bpu_conf_pkg::*, bpu_types_pkg::*;
();

  localparam int N_OPS = 420;

  typedef struct packed {
    logic       v;
    pred_resp_t r;
  } exp_entry_t;

  logic clk, rst;
  logic lookup_valid, lookup_is_cond, lookup_is_call, lookup_is_ret, lookup_is_rvc;
  vaddr_t lookup_pc;
  logic pred_valid, pred_taken, pred_btb_hit;
  vaddr_t pred_target, pred_ras_prev_vaddr;
  bht_idx_t pred_gshare_index, pred_gshare_bhr;
  bim_t pred_bim_value;
  ras_idx_t pred_ras_index;
  logic update, dead, u_taken, u_misp, u_cond, u_call, u_ret, u_rvc;
  ras_idx_t u_ras_index;
  bim_t u_bim;
  vaddr_t u_pc, u_target, u_prev;
  bht_idx_t u_gidx, u_gbhr;

  // reference model state
  bim_t m_bht [2**GSHARE_BHT_W];
  bht_idx_t m_bhr;
  logic m_btb_v [BTB_ENTRY_SIZE];
  logic [BTB_TAG_W-1:0] m_btb_tag [BTB_ENTRY_SIZE];
  vaddr_t m_btb_tgt [BTB_ENTRY_SIZE];
  vaddr_t m_ras [RAS_ENTRY_SIZE];
  ras_idx_t m_ptr;

  exp_entry_t exp_pipe [$];
  exp_entry_t cur_exp;
  exp_entry_t chk;
  int mism_errors = 0;
  int other_errors = 0;
  int seed = 32'hbd9d_a830;
  string test_name = "reset";

  tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));

  bpu_top bpu_top_i (
    .clk(clk), .rst(rst),
    .lookup_valid(lookup_valid), .lookup_pc(lookup_pc),
    .lookup_is_cond(lookup_is_cond), .lookup_is_call(lookup_is_call),
    .lookup_is_ret(lookup_is_ret), .lookup_is_rvc(lookup_is_rvc),
    .pred_valid(pred_valid), .pred_taken(pred_taken), .pred_btb_hit(pred_btb_hit),
    .pred_target(pred_target), .pred_gshare_index(pred_gshare_index),
    .pred_gshare_bhr(pred_gshare_bhr), .pred_bim_value(pred_bim_value),
    .pred_ras_index(pred_ras_index), .pred_ras_prev_vaddr(pred_ras_prev_vaddr),
    .update(update), .dead(dead), .upd_taken(u_taken), .upd_mispredict(u_misp),
    .upd_is_cond(u_cond), .upd_is_call(u_call), .upd_is_ret(u_ret), .upd_is_rvc(u_rvc),
    .upd_ras_index(u_ras_index), .upd_bim_value(u_bim), .upd_pc_vaddr(u_pc),
    .upd_target_vaddr(u_target), .upd_ras_prev_vaddr(u_prev),
    .upd_gshare_index(u_gidx), .upd_gshare_bhr(u_gbhr)
  );

  // expected responses line up two edges after the lookup cycle
  always @(posedge clk) begin
    if (rst) begin
      exp_pipe.delete();
      chk <= '0;
    end else begin
      exp_pipe.push_back(cur_exp);
      if (exp_pipe.size() == 2) begin
        chk <= exp_pipe.pop_front();
      end
    end
  end

  a_rst_valid : assert property (@(posedge clk) $past(rst) |-> !pred_valid)
    else begin
      other_errors++;
      $display("pred_valid high during or right after reset");
    end
  a_valid : assert property (@(posedge clk) disable iff (rst) pred_valid == chk.v)
    else begin
      mism_errors++;
      $display("mismatch %s valid exp %0d act %0d", test_name, $sampled(chk.v),
               $sampled(pred_valid));
    end
  a_taken : assert property (@(posedge clk) disable iff (rst)
    chk.v |-> pred_taken === chk.r.taken && pred_btb_hit === chk.r.btb_hit)
    else begin
      mism_errors++;
      $display("mismatch %s taken/hit exp %0d/%0d act %0d/%0d", test_name,
               $sampled(chk.r.taken), $sampled(chk.r.btb_hit),
               $sampled(pred_taken), $sampled(pred_btb_hit));
    end
  a_target : assert property (@(posedge clk) disable iff (rst)
    chk.v && chk.r.taken |-> pred_target === chk.r.target_vaddr)
    else begin
      mism_errors++;
      $display("mismatch %s target exp %h act %h", test_name,
               $sampled(chk.r.target_vaddr), $sampled(pred_target));
    end
  a_gshare : assert property (@(posedge clk) disable iff (rst)
    chk.v |-> pred_gshare_index === chk.r.gshare_index &&
              pred_gshare_bhr === chk.r.gshare_bhr && pred_bim_value === chk.r.bim_value)
    else begin
      mism_errors++;
      $display("mismatch %s idx/bhr/bim exp %h/%h/%0d act %h/%h/%0d", test_name,
               $sampled(chk.r.gshare_index), $sampled(chk.r.gshare_bhr),
               $sampled(chk.r.bim_value), $sampled(pred_gshare_index),
               $sampled(pred_gshare_bhr), $sampled(pred_bim_value));
    end
  a_ras : assert property (@(posedge clk) disable iff (rst)
    chk.v |-> pred_ras_index === chk.r.ras_index &&
              pred_ras_prev_vaddr === chk.r.ras_prev_vaddr)
    else begin
      mism_errors++;
      $display("mismatch %s ras exp %0d/%h act %0d/%h", test_name,
               $sampled(chk.r.ras_index), $sampled(chk.r.ras_prev_vaddr),
               $sampled(pred_ras_index), $sampled(pred_ras_prev_vaddr));
    end

  function automatic vaddr_t link_addr(input vaddr_t pc, input logic rvc);
    return rvc ? pc + 32'd2 : pc + 32'd4;
  endfunction

  task automatic quiet_inputs();
    lookup_valid = 1'b0;
    update = 1'b0;
    cur_exp = '0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      quiet_inputs();
    end
  endtask

  // expected prediction from model state, then the lookup's own RAS action
  task automatic issue_lookup(input vaddr_t pc, input logic cond, input logic call,
                              input logic ret, input logic rvc);
    bht_idx_t idx;
    logic [BTB_IDX_W-1:0] bi;
    logic hit;
    @(posedge clk);
    #1;
    quiet_inputs();
    idx = pc[GSHARE_BHT_W+1:2] ^ m_bhr;
    bi = pc[BTB_IDX_W+1:2];
    hit = m_btb_v[bi] && (m_btb_tag[bi] == pc[VADDR_W-1:BTB_IDX_W+2]);
    cur_exp.v = 1'b1;
    cur_exp.r.btb_hit = hit;
    cur_exp.r.gshare_index = idx;
    cur_exp.r.gshare_bhr = m_bhr;
    cur_exp.r.bim_value = m_bht[idx];
    cur_exp.r.ras_index = m_ptr;
    cur_exp.r.ras_prev_vaddr = m_ras[m_ptr];
    if (ret) begin
      cur_exp.r.taken = 1'b1;
      cur_exp.r.target_vaddr = m_ras[m_ptr];
    end else begin
      cur_exp.r.taken = hit && (!cond || m_bht[idx][1]);
      cur_exp.r.target_vaddr = m_btb_tgt[bi];
    end
    if (call) begin
      m_ptr = m_ptr + 1'b1;
      m_ras[m_ptr] = link_addr(pc, rvc);
    end else if (ret) begin
      m_ptr = m_ptr - 1'b1;
    end
    lookup_valid = 1'b1;
    lookup_pc = pc;
    lookup_is_cond = cond;
    lookup_is_call = call;
    lookup_is_ret = ret;
    lookup_is_rvc = rvc;
  endtask

  task automatic wait_response(output pred_resp_t r);
    int n;
    n = 0;
    idle_cycles(1);
    while (!pred_valid && n < 8) begin
      idle_cycles(1);
      n++;
    end
    if (!pred_valid) begin
      other_errors++;
      $display("no prediction returned in %s", test_name);
    end
    r = '{pred_taken, pred_btb_hit, pred_target, pred_gshare_index, pred_gshare_bhr,
          pred_bim_value, pred_ras_index, pred_ras_prev_vaddr};
  endtask

  // one update beat and one idle cycle, so the next lookup sees the write
  task automatic send_update(input logic kill, input br_upd_t u);
    logic [BTB_IDX_W-1:0] bi;
    @(posedge clk);
    #1;
    quiet_inputs();
    update = 1'b1;
    dead = kill;
    {u_taken, u_misp, u_cond, u_call, u_ret, u_rvc, u_ras_index, u_bim, u_pc, u_target,
     u_prev, u_gidx, u_gbhr} = u;
    if (!kill) begin
      if (u.is_cond) begin
        if (u.taken) begin
          m_bht[u.gshare_index] = (u.bim_value == 2'd3) ? 2'd3 : u.bim_value + 2'd1;
        end else begin
          m_bht[u.gshare_index] = (u.bim_value == 2'd0) ? 2'd0 : u.bim_value - 2'd1;
        end
        m_bhr = {u.gshare_bhr[GSHARE_BHT_W-2:0], u.taken};
      end
      if (u.taken) begin
        bi = u.pc_vaddr[BTB_IDX_W+1:2];
        m_btb_v[bi] = 1'b1;
        m_btb_tag[bi] = u.pc_vaddr[VADDR_W-1:BTB_IDX_W+2];
        m_btb_tgt[bi] = u.target_vaddr;
      end
      if (u.mispredict) begin
        m_ptr = u.ras_index;
        m_ras[m_ptr] = u.ras_prev_vaddr;
        if (u.is_call) begin
          m_ptr = m_ptr + 1'b1;
          m_ras[m_ptr] = link_addr(u.pc_vaddr, u.is_rvc);
        end else if (u.is_ret) begin
          m_ptr = m_ptr - 1'b1;
        end
      end
    end
    idle_cycles(1);
  endtask

  function automatic br_upd_t make_upd(input logic taken, input logic misp,
                                       input logic cond, input logic call, input logic ret,
                                       input vaddr_t pc, input vaddr_t tgt,
                                       input pred_resp_t r);
    return '{taken, misp, cond, call, ret, 1'b0, r.ras_index, r.bim_value, pc, tgt,
             r.ras_prev_vaddr, r.gshare_index, r.gshare_bhr};
  endfunction

  initial begin
    #(N_OPS * 40 + 2000);
    $display("watchdog timeout in %s", test_name);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    pred_resp_t r;
    vaddr_t pc_a, pc_c;
    br_upd_t u;
    logic [127:0] rnd;
    logic [2:0] kind;
    for (int i = 0; i < 2**GSHARE_BHT_W; i++) begin
      m_bht[i] = 2'd1;
    end
    for (int i = 0; i < BTB_ENTRY_SIZE; i++) begin
      m_btb_v[i] = 1'b0;
    end
    m_bhr = '0;
    m_ptr = '0;
    quiet_inputs();
    dead = 1'b0;
    lookup_pc = '0;
    {lookup_is_cond, lookup_is_call, lookup_is_ret, lookup_is_rvc} = '0;
    {u_taken, u_misp, u_cond, u_call, u_ret, u_rvc, u_ras_index, u_bim, u_pc, u_target,
     u_prev, u_gidx, u_gbhr} = '0;
    @(negedge rst);

    issue_lookup($random(seed), 1'b1, 1'b0, 1'b0, 1'b0);
    wait_response(r);

    test_name = "btb";
    pc_a = $random(seed);
    send_update(1'b0, make_upd(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, pc_a, $random(seed), r));
    issue_lookup(pc_a, 1'b0, 1'b0, 1'b0, 1'b0);
    wait_response(r);
    send_update(1'b0, make_upd(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, pc_a ^ 32'h0100_0000,
                               $random(seed), r));
    issue_lookup(pc_a, 1'b0, 1'b0, 1'b0, 1'b0);
    wait_response(r);

    // feedback loop walks the counter up to 3 then down to 0
    test_name = "counter";
    pc_c = $random(seed);
    for (int i = 0; i < 24; i++) begin
      issue_lookup(pc_c, 1'b1, 1'b0, 1'b0, 1'b0);
      wait_response(r);
      send_update(1'b0, make_upd(i < 12, 1'b0, 1'b1, 1'b0, 1'b0, pc_c, pc_c + 32'h40, r));
    end

    test_name = "ras_lifo";
    for (int i = 0; i < 5; i++) begin
      issue_lookup($random(seed), 1'b0, 1'b1, 1'b0, logic'(i % 2));
    end
    for (int i = 0; i < 5; i++) begin
      issue_lookup($random(seed), 1'b0, 1'b0, 1'b1, 1'b0);
    end
    idle_cycles(3);

    test_name = "ras_repair";
    issue_lookup($random(seed), 1'b0, 1'b1, 1'b0, 1'b0);
    issue_lookup($random(seed), 1'b0, 1'b1, 1'b0, 1'b1);
    // let the call responses drain so the next one is the ret's own
    idle_cycles(2);
    pc_a = $random(seed);
    issue_lookup(pc_a, 1'b0, 1'b0, 1'b1, 1'b0);
    wait_response(r);
    issue_lookup($random(seed), 1'b0, 1'b1, 1'b0, 1'b0);
    issue_lookup($random(seed), 1'b0, 1'b1, 1'b0, 1'b0);
    send_update(1'b0, make_upd(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, pc_a, r.target_vaddr, r));
    issue_lookup($random(seed), 1'b0, 1'b0, 1'b1, 1'b0);
    wait_response(r);

    test_name = "dead";
    for (int i = 0; i < 6; i++) begin
      rnd = {$random(seed), $random(seed), $random(seed), $random(seed)};
      u = rnd[$bits(br_upd_t)-1:0];
      u.pc_vaddr = (i % 2 == 0) ? pc_c : pc_a;
      // a live copy of this record would touch counter, history, btb and ras
      u.taken = 1'b1;
      u.is_cond = 1'b1;
      u.mispredict = 1'b1;
      u.gshare_index = u.pc_vaddr[GSHARE_BHT_W+1:2] ^ m_bhr;
      send_update(1'b1, u);
      issue_lookup(u.pc_vaddr, 1'b1, 1'b0, 1'b1, 1'b0);
      wait_response(r);
    end

    test_name = "random";
    for (int i = 0; i < 300; i++) begin
      kind = 3'($random(seed));
      pc_a = {28'h0000_123, 4'($random(seed))};
      if (kind < 3'd5) begin
        issue_lookup(pc_a, kind[0], kind == 3'd2, kind == 3'd4, kind[1]);
      end else begin
        rnd = {$random(seed), $random(seed), $random(seed), $random(seed)};
        u = rnd[$bits(br_upd_t)-1:0];
        u.pc_vaddr = pc_a;
        if (u.is_call) begin
          u.is_ret = 1'b0;
        end
        send_update(1'b0, u);
      end
    end
    idle_cycles(4);

    $display("errors: %0d mismatch, %0d other", mism_errors, other_errors);
    if (mism_errors + other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/bpu_conf_pkg.sv
logic/bpu_types_pkg.sv
logic/bpu_stage.sv
logic/gshare_bht.sv
logic/btb.sv
logic/ras.sv
logic/bpu_top.sv
verification/tb_clk_gen.sv
verification/bpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= bpu_tb
FILELIST  ?= verilog.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
